/* src.f */
design/board_pkg.sv
design/eval_pkg.sv
design/material_eval.sv
design/phase_counter.sv
design/phase_blend.sv
design/eval_sequencer.sv
design/evaluate.sv
tb/tb_evaluate.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_evaluate
FILELIST  ?= src.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "^No errors$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* tb/tb_evaluate.sv */
// Evaluator testbench
// Random and fixed boards against a model
`timescale 1ns/1ps
`default_nettype none

module tb_evaluate;
   import board_pkg::*;

   localparam int EVAL_WIDTH      = 16;
   localparam int CLK_PERIOD      = 100;
   localparam int DRIVE_DELAY     = 5;                  // Inputs change after the edge
   localparam int RESET_CYCLES    = 4;
   localparam int NUM_RANDOM      = 200;
   localparam int NUM_DISTURB     = 10;                 // Boards with a mid-run board_valid blip
   localparam int NUM_FIXED       = 3;
   localparam int TOTAL_BOARDS    = NUM_RANDOM + NUM_DISTURB + NUM_FIXED;
   localparam int WATCHDOG_CYCLES = TOTAL_BOARDS * 40;
   localparam int VALID_LIMIT     = 40;                 // Cycles to wait for eval_valid
   localparam int MAX_PER_COLOR   = 31;                 // Keeps one side's total in 16 bits
   localparam logic [2:0] BACK_RANK [8] = '{KIND_ROOK, KIND_KNIGHT, KIND_BISHOP, KIND_QUEEN,
                                            KIND_KING, KIND_BISHOP, KIND_KNIGHT, KIND_ROOK};

   logic                         clk = 1'b0;
   logic                         reset;
   logic                         board_valid;
   logic                         clear_eval;
   board_t                       board_in;
   logic signed [EVAL_WIDTH-1:0] eval;
   logic                         eval_valid;
   logic [31:0]                  rng_state = 32'h8c14_cab3;
   int                           errors = 0;
   int                           checks = 0;

   evaluate #(.EVAL_WIDTH(EVAL_WIDTH)) dut (
      .clk         (clk),
      .reset       (reset),
      .board_valid (board_valid),
      .clear_eval  (clear_eval),
      .board_in    (board_in),
      .eval        (eval),
      .eval_valid  (eval_valid)
   );

   always #(CLK_PERIOD / 2) clk = ~clk;                 // 100 ns period

   function automatic logic [31:0] xorshift32(input logic [31:0] x);
      logic [31:0] y;
      y = x ^ (x << 13);
      y = y ^ (y >> 17);
      y = y ^ (y << 5);
      return y;
   endfunction

   function logic [31:0] next_random();
      rng_state = xorshift32(rng_state);
      return rng_state;
   endfunction

   // Piece values by kind, kings and empty codes score nothing
   function automatic longint piece_score(input logic [2:0] kind, input bit endgame);
      case (kind)
         KIND_PAWN:   return endgame ? 94 : 82;
         KIND_KNIGHT: return endgame ? 281 : 337;
         KIND_BISHOP: return endgame ? 297 : 365;
         KIND_ROOK:   return endgame ? 512 : 477;
         KIND_QUEEN:  return endgame ? 936 : 1025;
         default:     return 0;
      endcase
   endfunction

   // Expected score, white minus black, tapered by phase
   function automatic longint model_eval(input board_t b);
      logic [PIECE_WIDTH-1:0] piece;
      longint                 mg;
      longint                 eg;
      longint                 phase;
      mg = 0;
      eg = 0;
      phase = 0;
      for (int sq = 0; sq < NUM_SQUARES; sq++)
      begin
         piece = b[sq*PIECE_WIDTH +: PIECE_WIDTH];
         if (piece[PIECE_WIDTH-1])                      // Black side subtracts
         begin
            mg -= piece_score(piece[2:0], 1'b0);
            eg -= piece_score(piece[2:0], 1'b1);
         end
         else
         begin
            mg += piece_score(piece[2:0], 1'b0);
            eg += piece_score(piece[2:0], 1'b1);
         end
         if (piece[2:0] >= KIND_KNIGHT && piece[2:0] <= KIND_KING)
            phase++;                                    // Non-pawn piece of either color
      end
      if (phase > 62)
         phase = 62;
      return ((mg * phase + eg * (62 - phase)) * 16912) / 1048576; // Truncates toward zero
   endfunction

   function automatic board_t random_board();
      board_t      b;
      int          density;
      int          count [2];
      logic [31:0] r;
      b = '0;
      count[0] = 0;
      count[1] = 0;
      density = next_random() % 101;                    // Percent of squares filled
      for (int sq = 0; sq < NUM_SQUARES; sq++)
      begin
         r = next_random();
         if ((r[31:16] % 100) < density && count[r[3]] < MAX_PER_COLOR)
         begin
            b[sq*PIECE_WIDTH +: PIECE_WIDTH] = r[3:0]; // Any kind, any color
            count[r[3]]++;
         end
      end
      return b;
   endfunction

   function automatic board_t opening_board();
      board_t b;
      b = '0;
      for (int f = 0; f < 8; f++)
      begin
         b[f*PIECE_WIDTH +: PIECE_WIDTH]      = {1'b0, BACK_RANK[f]}; // White back rank
         b[(8+f)*PIECE_WIDTH +: PIECE_WIDTH]  = {1'b0, KIND_PAWN};
         b[(48+f)*PIECE_WIDTH +: PIECE_WIDTH] = {1'b1, KIND_PAWN};
         b[(56+f)*PIECE_WIDTH +: PIECE_WIDTH] = {1'b1, BACK_RANK[f]}; // Mirrored black
      end
      return b;
   endfunction

   // Queen and both kings, phase 3
   function automatic board_t queen_board();
      board_t b;
      b = '0;
      b[3*PIECE_WIDTH +: PIECE_WIDTH]  = {1'b0, KIND_QUEEN};
      b[4*PIECE_WIDTH +: PIECE_WIDTH]  = {1'b0, KIND_KING};
      b[60*PIECE_WIDTH +: PIECE_WIDTH] = {1'b1, KIND_KING};
      return b;
   endfunction

   task automatic next_cycle();
      @(posedge clk);
      #DRIVE_DELAY;
   endtask

   task automatic check_idle(input string when);
      checks++;
      if (eval_valid !== 1'b0)
      begin
         $display("Error at %0t: eval_valid high %s", $time, when);
         errors++;
      end
   endtask

   // One evaluation from board_valid edge to clear_eval
   task automatic run_board(input board_t b, input longint expected, input bit disturb);
      logic signed [EVAL_WIDTH-1:0] want;
      int                           waited;
      int                           hold_cycles;
      want = EVAL_WIDTH'(expected);
      waited = 0;
      board_in    = b;
      board_valid = 1'b1;
      next_cycle();                                     // Edge seen here
      if (disturb)
      begin
         next_cycle();
         board_valid = 1'b0;                            // Drop while busy
         board_in    = random_board();
         next_cycle();
         board_valid = 1'b1;                            // Re-rise must be ignored
      end
      while (eval_valid !== 1'b1 && waited < VALID_LIMIT)
      begin
         next_cycle();
         waited++;
      end
      checks++;
      if (eval_valid !== 1'b1)
      begin
         $display("Error at %0t: eval_valid did not rise within %0d cycles", $time,
                  VALID_LIMIT);
         errors++;
      end
      else
      begin
         if (eval !== want)
         begin
            $display("Error at %0t: eval %0d, expected %0d", $time, eval, want);
            errors++;
         end
         hold_cycles = next_random() % 11;             // Withhold clear_eval 0 to 10 cycles
         repeat (hold_cycles)
         begin
            next_cycle();
            checks++;
            if (eval_valid !== 1'b1 || eval !== want)
            begin
               $display("Error at %0t: result not held, eval_valid %b eval %0d, expected %0d",
                        $time, eval_valid, eval, want);
               errors++;
            end
         end
      end
      clear_eval  = 1'b1;
      board_valid = 1'b0;
      next_cycle();
      clear_eval = 1'b0;
      check_idle("after clear_eval");
   endtask

   initial
   begin
      board_t b;
      reset       = 1'b1;
      board_valid = 1'b0;
      clear_eval  = 1'b0;
      board_in    = '0;
      repeat (RESET_CYCLES)
      begin
         next_cycle();
         check_idle("during reset");
      end
      reset = 1'b0;
      next_cycle();
      check_idle("after reset");

      run_board('0, 0, 1'b0);                           // Empty board
      run_board(opening_board(), 0, 1'b0);              // Symmetric start position
      b = queen_board();
      run_board(b, model_eval(b), 1'b0);

      for (int i = 0; i < NUM_RANDOM; i++)
      begin
         b = random_board();
         run_board(b, model_eval(b), 1'b0);
      end
      for (int i = 0; i < NUM_DISTURB; i++)
      begin
         b = random_board();
         run_board(b, model_eval(b), 1'b1);
      end

      $display("Checks: %0d, errors: %0d", checks, errors);
      if (errors == 0)
         $display("No errors");
      else
         $display("Errors found");
      $finish;
   end

   // Bound on total run length
   initial
   begin
      repeat (WATCHDOG_CYCLES) @(posedge clk);
      $display("Timeout: simulation ran past %0d cycles", WATCHDOG_CYCLES);
      $display("Errors found");
      $finish;
   end

endmodule

`default_nettype wire

/* design/evaluate.sv */
// Static evaluator top level
`timescale 1ns/1ps
`default_nettype none

module evaluate #(
   parameter int EVAL_WIDTH = 16
) (
   input  logic                          clk,
   input  logic                          reset,
   input  logic                          board_valid,
   input  logic                          clear_eval,
   input  board_pkg::board_t             board_in,
   output logic signed [EVAL_WIDTH-1:0]  eval,
   output logic                          eval_valid
);
   import board_pkg::*;
   import eval_pkg::*;

   board_t                       board;          // Captured board to all units
   logic                         start;
   logic [EVAL_UNITS-1:0]        unit_done;      // White, black, phase
   logic signed [EVAL_WIDTH-1:0] mg_white;
   logic signed [EVAL_WIDTH-1:0] eg_white;
   logic signed [EVAL_WIDTH-1:0] mg_black;
   logic signed [EVAL_WIDTH-1:0] eg_black;
   phase_t                       phase;

   eval_sequencer sequencer (
      .clk         (clk),
      .reset       (reset),
      .board_valid (board_valid),
      .clear_eval  (clear_eval),
      .board_in    (board_in),
      .unit_done   (unit_done),
      .board       (board),
      .start       (start),
      .eval_valid  (eval_valid)
   );

   material_eval #(.EVAL_WIDTH(EVAL_WIDTH), .SIDE_WHITE(1'b1)) material_white (
      .clk (clk), .reset (reset), .board (board), .start (start),
      .mg  (mg_white), .eg (eg_white), .done (unit_done[0])
   );

   material_eval #(.EVAL_WIDTH(EVAL_WIDTH), .SIDE_WHITE(1'b0)) material_black (
      .clk (clk), .reset (reset), .board (board), .start (start),
      .mg  (mg_black), .eg (eg_black), .done (unit_done[1])
   );

   phase_counter phase_count (
      .clk (clk), .reset (reset), .board (board), .start (start),
      .phase (phase), .done (unit_done[2])
   );

   phase_blend #(.EVAL_WIDTH(EVAL_WIDTH)) blend (
      .clk      (clk),
      .mg_white (mg_white),
      .eg_white (eg_white),
      .mg_black (mg_black),
      .eg_black (eg_black),
      .phase    (phase),
      .eval     (eval)
   );

endmodule

`default_nettype wire

/* design/eval_sequencer.sv */
// Evaluation sequencer
// Board capture, unit tracking and result hold
`timescale 1ns/1ps
`default_nettype none

module eval_sequencer (
   input  logic                            clk,
   input  logic                            reset,
   input  logic                            board_valid,
   input  logic                            clear_eval,
   input  board_pkg::board_t               board_in,
   input  logic [eval_pkg::EVAL_UNITS-1:0] unit_done,
   output board_pkg::board_t               board,
   output logic                            start,
   output logic                            eval_valid
);
   import board_pkg::*;
   import eval_pkg::*;

   localparam int LAT_W = $clog2(BLEND_LATENCY);

   typedef enum logic [2:0] {
      ST_IDLE,
      ST_SETTLE,                                 // Board passes second flop
      ST_WAIT_UNITS,
      ST_WAIT_LATENCY,                           // Blend pipeline drains
      ST_HOLD
   } state_t;

   state_t                state;
   board_t                board_pre;
   logic                  board_valid_q;
   logic                  board_edge;
   logic [EVAL_UNITS-1:0] done_q;
   logic [EVAL_UNITS-1:0] done_locked;           // Sticky per unit
   logic [LAT_W-1:0]      latency_count;

   assign board_edge = board_valid & ~board_valid_q;

   always_ff @(posedge clk)
   begin
      if (state == ST_IDLE)
         board_pre <= board_in;                  // Tracks input until an edge
      board <= board_pre;                        // Flopped again for timing
   end

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         state         <= ST_IDLE;
         board_valid_q <= 1'b0;
         done_q        <= '0;
         done_locked   <= '0;
         latency_count <= '0;
         start         <= 1'b0;
         eval_valid    <= 1'b0;
      end
      else
      begin
         board_valid_q <= board_valid;
         done_q        <= unit_done;
         done_locked   <= done_locked | (unit_done & ~done_q); // Lock on rising edge
         case (state)
            ST_IDLE:
               if (board_edge)
                  state <= ST_SETTLE;
            ST_SETTLE:
            begin
               done_locked   <= '0;              // Fresh evaluation
               latency_count <= '0;
               start         <= 1'b1;
               state         <= ST_WAIT_UNITS;
            end
            ST_WAIT_UNITS:
               if (&done_locked)
                  state <= ST_WAIT_LATENCY;
            ST_WAIT_LATENCY:
            begin
               latency_count <= latency_count + 1'b1;
               if (latency_count == LAT_W'(BLEND_LATENCY - 1))
               begin
                  eval_valid <= 1'b1;
                  state      <= ST_HOLD;
               end
            end
            ST_HOLD:
               if (clear_eval)
               begin
                  eval_valid <= 1'b0;
                  start      <= 1'b0;            // Units drop done with start
                  state      <= ST_IDLE;
               end
            default:
            begin
               start      <= 1'b0;
               eval_valid <= 1'b0;
               state      <= ST_IDLE;
            end
         endcase
      end
   end

   a_valid_needs_lock: assert property (@(posedge clk) disable iff (reset)
      $rose(eval_valid) |-> &done_locked);

   a_idle_no_start: assert property (@(posedge clk) disable iff (reset)
      state == ST_IDLE |-> !start);

endmodule

`default_nettype wire

/* design/phase_blend.sv */
// Phase blend pipeline
// Tapered mix of middlegame and endgame terms
`timescale 1ns/1ps
`default_nettype none

module phase_blend #(
   parameter int EVAL_WIDTH = 16
) (
   input  logic                          clk,
   input  logic signed [EVAL_WIDTH-1:0]  mg_white,
   input  logic signed [EVAL_WIDTH-1:0]  eg_white,
   input  logic signed [EVAL_WIDTH-1:0]  mg_black,
   input  logic signed [EVAL_WIDTH-1:0]  eg_black,
   input  eval_pkg::phase_t              phase,
   output logic signed [EVAL_WIDTH-1:0]  eval
);
   import eval_pkg::*;

   localparam int SUM_W   = EVAL_WIDTH + SUM_GUARD;
   localparam int PROD_W  = SUM_W + $bits(phase_t) + 1;   // Times signed 9-bit weight
   localparam int TOTAL_W = PROD_W + 1;
   localparam int SCALE_W = TOTAL_W + 16;                 // Times signed reciprocal
   localparam logic signed [SCALE_W-1:0] ROUND_BIAS = SCALE_W'((1 << PHASE_SHIFT) - 1);

   logic signed [SUM_W-1:0]   mg_sum;
   logic signed [SUM_W-1:0]   eg_sum;
   phase_t                    phase_s1;          // Aligned with the sums
   phase_t                    eg_weight;
   logic signed [PROD_W-1:0]  mg_prod;
   logic signed [PROD_W-1:0]  eg_prod;
   logic signed [PROD_W-1:0]  mg_prod_r;
   logic signed [PROD_W-1:0]  eg_prod_r;
   logic signed [TOTAL_W-1:0] total;
   logic signed [SCALE_W-1:0] scaled;
   logic signed [SCALE_W-1:0] rounded;

   assign eg_weight = phase_t'(PHASE_MAX) - phase_s1;
   // Bias negatives so the shift truncates toward zero
   assign rounded = scaled + (scaled[SCALE_W-1] ? ROUND_BIAS : '0);

   always_ff @(posedge clk)
   begin
      // Stage 1
      mg_sum   <= SUM_W'(mg_white) + SUM_W'(mg_black);
      eg_sum   <= SUM_W'(eg_white) + SUM_W'(eg_black);
      phase_s1 <= phase;

      // Stage 2
      mg_prod <= PROD_W'(mg_sum) * PROD_W'($signed({1'b0, phase_s1}));
      eg_prod <= PROD_W'(eg_sum) * PROD_W'($signed({1'b0, eg_weight}));

      // Stage 3, timing only
      mg_prod_r <= mg_prod;
      eg_prod_r <= eg_prod;

      // Stage 4
      total <= TOTAL_W'(mg_prod_r) + TOTAL_W'(eg_prod_r);

      // Stage 5, divide by 62 as multiply by reciprocal
      scaled <= SCALE_W'(total) * SCALE_W'(PHASE_RECIP);

      // Stage 6
      eval <= EVAL_WIDTH'(rounded >>> PHASE_SHIFT);
   end

endmodule

`default_nettype wire

/* design/phase_counter.sv */
// Game phase counter
`timescale 1ns/1ps
`default_nettype none

module phase_counter (
   input  logic              clk,
   input  logic              reset,
   input  board_pkg::board_t board,
   input  logic              start,
   output eval_pkg::phase_t  phase,
   output logic              done
);
   import board_pkg::*;
   import eval_pkg::*;

   localparam int COUNT_W = $clog2(NUM_SQUARES + 1);

   logic [NUM_SQUARES-1:0] heavy;                // Occupied by neither pawn nor empty
   logic [COUNT_W-1:0]     heavy_count_d;
   logic [COUNT_W-1:0]     heavy_count;
   logic [1:0]             start_pipe;

   always_comb
   begin
      heavy_count_d = '0;
      for (int sq = 0; sq < NUM_SQUARES; sq++)
      begin
         heavy[sq] = (board[sq*PIECE_WIDTH +: 3] != KIND_EMPTY) &&
                     (board[sq*PIECE_WIDTH +: 3] != KIND_PAWN) &&
                     (board[sq*PIECE_WIDTH +: 3] <= KIND_KING); // Kind 7 is empty
         heavy_count_d += COUNT_W'(heavy[sq]);
      end
   end

   always_ff @(posedge clk)
   begin
      heavy_count <= heavy_count_d;              // Popcount stage
      if (heavy_count > COUNT_W'(PHASE_MAX))     // Clamp stage
         phase <= phase_t'(PHASE_MAX);
      else
         phase <= phase_t'(heavy_count);
   end

   always_ff @(posedge clk)
   begin
      if (reset)
         start_pipe <= '0;
      else
         start_pipe <= {start_pipe[0] & start, start};
   end

   assign done = start & start_pipe[1];

   a_phase_clamped: assert property (@(posedge clk) disable iff (reset)
      done |-> phase <= PHASE_MAX);

endmodule

`default_nettype wire

/* design/material_eval.sv */
// Material counter
// One color, middlegame and endgame terms
`timescale 1ns/1ps
`default_nettype none

module material_eval #(
   parameter int EVAL_WIDTH = 16,
   parameter bit SIDE_WHITE = 1'b1
) (
   input  logic                          clk,
   input  logic                          reset,
   input  board_pkg::board_t             board,
   input  logic                          start,
   output logic signed [EVAL_WIDTH-1:0]  mg,
   output logic signed [EVAL_WIDTH-1:0]  eg,
   output logic                          done
);
   import board_pkg::*;
   import eval_pkg::*;

   localparam int   SUM_W      = EVAL_WIDTH + SUM_GUARD;
   localparam int   RANKS      = NUM_SQUARES / 8;
   localparam logic SIDE_COLOR = SIDE_WHITE ? 1'b0 : 1'b1; // Color bit of our pieces

   logic [SUM_W-1:0]        mg_rank_d [RANKS];   // Level one, per-rank sums
   logic [SUM_W-1:0]        eg_rank_d [RANKS];
   logic [SUM_W-1:0]        mg_rank   [RANKS];
   logic [SUM_W-1:0]        eg_rank   [RANKS];
   logic [SUM_W-1:0]        mg_sum;              // Level two, whole board
   logic [SUM_W-1:0]        eg_sum;
   logic signed [SUM_W-1:0] mg_total;
   logic signed [SUM_W-1:0] eg_total;
   logic [1:0]              start_pipe;          // Tracks adder tree fill

   // Value of one square, zero for the other color or no piece
   function automatic int unsigned piece_value(input piece_t piece, input bit endgame);
      int unsigned value;
      value = 0;
      if (piece[PIECE_WIDTH-1] == SIDE_COLOR)
      begin
         case (piece[PIECE_WIDTH-2:0])
            KIND_PAWN:   value = endgame ? EG_VALUE[0] : MG_VALUE[0];
            KIND_KNIGHT: value = endgame ? EG_VALUE[1] : MG_VALUE[1];
            KIND_BISHOP: value = endgame ? EG_VALUE[2] : MG_VALUE[2];
            KIND_ROOK:   value = endgame ? EG_VALUE[3] : MG_VALUE[3];
            KIND_QUEEN:  value = endgame ? EG_VALUE[4] : MG_VALUE[4];
            KIND_KING:   value = endgame ? EG_VALUE[5] : MG_VALUE[5];
            default:     value = 0;              // Empty codes
         endcase
      end
      return value;
   endfunction

   always_comb
   begin
      for (int r = 0; r < RANKS; r++)
      begin
         mg_rank_d[r] = '0;
         eg_rank_d[r] = '0;
         for (int f = 0; f < 8; f++)
         begin
            mg_rank_d[r] += SUM_W'(piece_value(board[(r*8+f)*PIECE_WIDTH +: PIECE_WIDTH], 1'b0));
            eg_rank_d[r] += SUM_W'(piece_value(board[(r*8+f)*PIECE_WIDTH +: PIECE_WIDTH], 1'b1));
         end
      end
   end

   always_comb
   begin
      mg_sum = '0;
      eg_sum = '0;
      for (int r = 0; r < RANKS; r++)
      begin
         mg_sum += mg_rank[r];
         eg_sum += eg_rank[r];
      end
   end

   always_ff @(posedge clk)
   begin
      mg_rank  <= mg_rank_d;
      eg_rank  <= eg_rank_d;
      mg_total <= SIDE_WHITE ? mg_sum : -mg_sum; // Black counts against white
      eg_total <= SIDE_WHITE ? eg_sum : -eg_sum;
   end

   always_ff @(posedge clk)
   begin
      if (reset)
         start_pipe <= '0;
      else
         start_pipe <= {start_pipe[0] & start, start}; // Drops out as soon as start falls
   end

   assign mg   = mg_total[EVAL_WIDTH-1:0];
   assign eg   = eg_total[EVAL_WIDTH-1:0];
   assign done = start & start_pipe[1];          // Two cycles after start

   // Terms only reported once the tree has seen the board for two cycles
   a_done_after_start: assert property (@(posedge clk) disable iff (reset)
      done |-> start && $past(start, 2));

endmodule

`default_nettype wire

/* design/eval_pkg.sv */
// Evaluator constants
// Piece values, phase scaling, pipeline sizes
`default_nettype none

package eval_pkg;

   // Game phase
   localparam int PHASE_MAX = 62;                  // Clamp for non-pawn count
   typedef logic [7:0] phase_t;                    // Unsigned phase value

   // Fixed-point reciprocal of PHASE_MAX
   localparam int PHASE_SHIFT = 20;                // Scale is 2^20
   localparam int PHASE_RECIP = 16912;             // floor(2^20 / 62)

   // Piece values, index 0 is pawn through 5 is king
   localparam int unsigned MG_VALUE [6] = '{82, 337, 365, 477, 1025, 0};
   localparam int unsigned EG_VALUE [6] = '{94, 281, 297, 512, 936, 0};

   // Evaluator units reporting done
   localparam int EVAL_UNITS = 3;                  // White, black material and phase

   localparam int BLEND_LATENCY = 6;               // Stages in phase_blend
   localparam int SUM_GUARD = 4;                   // Headroom bits in term sums

endpackage

`default_nettype wire

/* design/board_pkg.sv */
// Board encoding
// Square layout and piece codes
`default_nettype none

package board_pkg;

   localparam int NUM_SQUARES = 64;                        // Full 8x8 board
   localparam int PIECE_WIDTH = 4;                         // Color bit over 3-bit kind
   localparam int BOARD_WIDTH = NUM_SQUARES * PIECE_WIDTH; // 256 bits packed

   typedef logic [PIECE_WIDTH-1:0] piece_t;                // MSB set means black
   typedef logic [BOARD_WIDTH-1:0] board_t;                // Square 0 in bits 3:0

   // Kind codes in the low three bits
   localparam logic [2:0] KIND_EMPTY  = 3'd0;
   localparam logic [2:0] KIND_PAWN   = 3'd1;
   localparam logic [2:0] KIND_KNIGHT = 3'd2;
   localparam logic [2:0] KIND_BISHOP = 3'd3;
   localparam logic [2:0] KIND_ROOK   = 3'd4;
   localparam logic [2:0] KIND_QUEEN  = 3'd5;
   localparam logic [2:0] KIND_KING   = 3'd6;
   // Kind 7 and black-empty code 8 are treated as empty squares

endpackage

`default_nettype wire
